// ==== src/fdiv_pkg.sv ====
package fdiv_pkg;

	localparam int EXP_W = 14;
	localparam int OPEXP_W = 12;
	localparam int FRAC_W = 52;
	localparam int REM_W = 57;
	localparam int QUO_W = 55;
	localparam int NORM_W = 165;
	localparam int MANT_W = 54;
	localparam int SINGLE_MANT_W = 24;
	localparam int DOUBLE_MANT_W = 53;
	localparam int IDX_W = 6;
	localparam int CLASS_W = 10;

	localparam logic signed [EXP_W-1:0] BIAS_SINGLE = 14'sd127;
	localparam logic signed [EXP_W-1:0] BIAS_DOUBLE = 14'sd1023;
	localparam logic signed [EXP_W-1:0] SQRT_EXP_OFFSET = -14'sd2045;

	localparam logic [IDX_W-1:0] DIV_FIRST_BIT = 6'd54;
	localparam logic [IDX_W-1:0] SQRT_FIRST_BIT = 6'd53;
	localparam logic [IDX_W-1:0] SINGLE_LAST_BIT = 6'd29;
	localparam int SUBNORMAL_MAX_SHIFT = 54;
	localparam logic [OPEXP_W-1:0] SQRT_DIVISOR_EXP = 12'd2047;

	// Bit positions inside the one-hot operand class
	localparam int CLS_NEG_INF = 0;
	localparam int CLS_NEG_NORM = 1;
	localparam int CLS_NEG_SUB = 2;
	localparam int CLS_NEG_ZERO = 3;
	localparam int CLS_POS_ZERO = 4;
	localparam int CLS_POS_SUB = 5;
	localparam int CLS_POS_NORM = 6;
	localparam int CLS_POS_INF = 7;
	localparam int CLS_SNAN = 8;
	localparam int CLS_QNAN = 9;

	typedef enum logic [1:0] {op_none, op_div, op_sqrt} fdiv_op_t;
	typedef enum logic [1:0] {st_idle, st_iterate, st_normalize, st_done} fdiv_state_t;

	typedef logic [CLASS_W-1:0] fp_class_t;

	typedef struct packed {
		logic sign;
		logic [OPEXP_W-1:0] exponent;
		logic [FRAC_W-1:0] fraction;
	} operand_t;

	typedef struct packed {
		fdiv_op_t op;
		operand_t data1;
		operand_t data2;
		fp_class_t class1;
		fp_class_t class2;
		logic fmt;
		logic [2:0] rm;
	} fdiv_request_t;

	typedef struct packed {
		logic snan;
		logic qnan;
		logic dbz;
		logic inf;
		logic zero;
	} fdiv_flags_t;

	typedef struct packed {
		logic sign;
		logic signed [EXP_W-1:0] exponent;
		logic fmt;
		logic [2:0] rm;
		fdiv_flags_t flags;
		logic is_sqrt;
	} fdiv_header_t;

	typedef struct packed {
		logic sign;
		logic [EXP_W-1:0] exponent;
		logic [MANT_W-1:0] mantissa;
		logic [2:0] grs;
		logic fmt;
		logic [2:0] rm;
		fdiv_flags_t flags;
	} fdiv_result_t;

endpackage

// ==== src/fdiv_control.sv ====
`timescale 1ns/100ps

module fdiv_control
	import fdiv_pkg::*;
(
	input  logic             clock,
	input  logic             reset,
	input  fdiv_op_t         op_i,
	input  logic             header_fmt_i,
	output logic             start_o,
	output logic             iterate_en_o,
	output logic [IDX_W-1:0] bit_index_o,
	output logic             norm_en_o,
	output logic             ready_o
);

	fdiv_state_t state;
	fdiv_state_t state_next;
	logic [IDX_W-1:0] bit_index;
	logic last_bit;

	assign start_o = (state == st_idle) && (op_i != op_none); // Requests while busy are dropped
	assign iterate_en_o = state == st_iterate;
	assign norm_en_o = state == st_normalize;
	assign ready_o = state == st_done;
	assign bit_index_o = bit_index;

	// Single format needs only the upper quotient bits
	assign last_bit = header_fmt_i ? (bit_index == '0) : (bit_index == SINGLE_LAST_BIT);

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (start_o) begin
					state_next = st_iterate;
				end
			end
			st_iterate: begin
				if (last_bit) begin
					state_next = st_normalize;
				end
			end
			st_normalize: state_next = st_done;
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			state <= st_idle;
			bit_index <= '0;
		end else begin
			state <= state_next;
			if (start_o) begin
				bit_index <= (op_i == op_sqrt) ? SQRT_FIRST_BIT : DIV_FIRST_BIT;
			end else if (iterate_en_o && !last_bit) begin
				bit_index <= bit_index - 1'b1;
			end
		end
	end

	a_start_in_idle: assert property (@(posedge clock) disable iff (!reset)
		start_o |=> !start_o && iterate_en_o
			&& (bit_index_o == DIV_FIRST_BIT || bit_index_o == SQRT_FIRST_BIT));

	a_ready_to_idle: assert property (@(posedge clock) disable iff (!reset)
		ready_o |=> state == st_idle);

endmodule

// ==== src/fdiv_classify.sv ====
`timescale 1ns/100ps

module fdiv_classify
	import fdiv_pkg::*;
(
	input  logic          clock,
	input  logic          reset,
	input  logic          start_i,
	input  fdiv_request_t request_i,
	output fdiv_header_t  header_o
);

	fdiv_header_t header_d;
	fdiv_header_t header_q;
	operand_t divisor;
	fp_class_t class_a;
	fp_class_t class_b;
	logic is_sqrt;
	logic a_zero;
	logic a_inf;
	logic a_finite_nz;
	logic b_zero;
	logic b_inf;
	logic b_finite;

	assign is_sqrt = request_i.op == op_sqrt;
	assign class_a = request_i.class1;
	assign class_b = is_sqrt ? '0 : request_i.class2; // The root divisor has no class
	assign divisor = is_sqrt ? '{sign: 1'b0, exponent: SQRT_DIVISOR_EXP, fraction: '0}
		: request_i.data2;

	assign a_zero = class_a[CLS_NEG_ZERO] | class_a[CLS_POS_ZERO];
	assign a_inf = class_a[CLS_NEG_INF] | class_a[CLS_POS_INF];
	assign a_finite_nz = class_a[CLS_NEG_NORM] | class_a[CLS_NEG_SUB]
		| class_a[CLS_POS_SUB] | class_a[CLS_POS_NORM];
	assign b_zero = class_b[CLS_NEG_ZERO] | class_b[CLS_POS_ZERO];
	assign b_inf = class_b[CLS_NEG_INF] | class_b[CLS_POS_INF];
	assign b_finite = |class_b[CLS_POS_NORM:CLS_NEG_NORM];

	always_comb begin
		header_d = '0;
		header_d.sign = request_i.data1.sign ^ divisor.sign;
		header_d.exponent = {{(EXP_W-OPEXP_W){1'b0}}, request_i.data1.exponent}
			- {{(EXP_W-OPEXP_W){1'b0}}, divisor.exponent};
		if (is_sqrt) begin
			header_d.exponent = ($signed({{(EXP_W-OPEXP_W){1'b0}}, request_i.data1.exponent})
				+ SQRT_EXP_OFFSET) >>> 1;
		end
		header_d.flags.snan = class_a[CLS_SNAN] | class_b[CLS_SNAN]
			| (a_zero & b_zero) | (a_inf & b_inf);
		header_d.flags.qnan = !header_d.flags.snan & (class_a[CLS_QNAN] | class_b[CLS_QNAN]);
		if (a_inf & b_finite) begin
			header_d.flags.inf = 1'b1;
		end else if (b_zero & a_finite_nz) begin
			header_d.flags.dbz = 1'b1;
		end
		header_d.flags.zero = a_zero | b_inf;
		if (is_sqrt) begin
			header_d.flags.inf = header_d.flags.inf | class_a[CLS_POS_INF];
			header_d.flags.snan = header_d.flags.snan | (|class_a[CLS_NEG_SUB:CLS_NEG_INF]);
		end
		header_d.fmt = request_i.fmt;
		header_d.rm = request_i.rm;
		header_d.is_sqrt = is_sqrt;
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			header_q <= '0;
		end else if (start_i) begin
			header_q <= header_d;
		end
	end

	// The new header is forwarded in the start cycle so the recurrence loads in the right mode
	assign header_o = start_i ? header_d : header_q;

	a_class_onehot: assert property (@(posedge clock) disable iff (!reset)
		start_i |-> $onehot(request_i.class1) && (is_sqrt || $onehot(request_i.class2)));

endmodule

// ==== src/fdiv_iterate.sv ====
`timescale 1ns/100ps

module fdiv_iterate
	import fdiv_pkg::*;
(
	input  logic             clock,
	input  logic             reset,
	input  logic             start_i,
	input  logic             is_sqrt_i,
	input  logic             iterate_en_i,
	input  logic [IDX_W-1:0] bit_index_i,
	input  operand_t         dividend_i,
	input  operand_t         divisor_i,
	output logic [QUO_W-1:0] quotient_o,
	output logic [REM_W-1:0] remainder_o
);

	logic [QUO_W-1:0] quotient;
	logic [REM_W-1:0] remainder;
	logic [REM_W-1:0] subtrahend;
	logic [REM_W-1:0] remainder_init;
	logic [REM_W-1:0] subtrahend_init;
	logic [REM_W-1:0] root_trial;
	logic [REM_W-1:0] trial;
	logic [REM_W-1:0] doubled;
	logic [REM_W-1:0] difference;

	always_comb begin
		remainder_init = {{(REM_W-FRAC_W-1){1'b0}}, 1'b1, dividend_i.fraction};
		if (is_sqrt_i && !dividend_i.exponent[0]) begin
			remainder_init = remainder_init << 1; // Even biased exponent means an odd true exponent
		end
		subtrahend_init = {{(REM_W-FRAC_W-2){1'b0}}, 1'b1, divisor_i.fraction, 1'b0};
		if (is_sqrt_i) begin
			subtrahend_init = '0;
		end
	end

	always_comb begin
		root_trial = {1'b0, quotient, 1'b0};
		root_trial[bit_index_i] = 1'b1; // Root trial is twice the partial root plus the new bit
		trial = is_sqrt_i ? root_trial : subtrahend;
		doubled = {remainder[REM_W-2:0], 1'b0};
		difference = doubled - trial;
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			quotient <= '0;
			remainder <= '0;
			subtrahend <= '0;
		end else if (start_i) begin
			quotient <= '0;
			remainder <= remainder_init;
			subtrahend <= subtrahend_init;
		end else if (iterate_en_i) begin
			if (!difference[REM_W-1]) begin
				quotient[bit_index_i] <= 1'b1;
				remainder <= difference;
			end else begin
				remainder <= doubled; // Restore by keeping the doubled remainder
			end
		end
	end

	assign quotient_o = quotient;
	assign remainder_o = remainder;

endmodule

// ==== src/fdiv_normalize.sv ====
`timescale 1ns/100ps

module fdiv_normalize
	import fdiv_pkg::*;
(
	input  logic             clock,
	input  logic             reset,
	input  logic             norm_en_i,
	input  fdiv_header_t     header_i,
	input  logic [QUO_W-1:0] quotient_i,
	input  logic [REM_W-1:0] remainder_i,
	output fdiv_result_t     result_o
);

	localparam int SINGLE_GUARD = NORM_W - SINGLE_MANT_W - 1;
	localparam int DOUBLE_GUARD = NORM_W - DOUBLE_MANT_W - 1;

	logic [NORM_W-1:0] window;
	logic [NORM_W-1:0] aligned;
	logic [NORM_W-1:0] shifted;
	logic norm_shift;
	logic signed [EXP_W-1:0] bias;
	logic signed [EXP_W-1:0] biased_exp;
	logic [IDX_W-1:0] sub_shift;
	fdiv_result_t result_d;
	fdiv_result_t result_q;

	always_comb begin
		window = {quotient_i, remainder_i[REM_W-2:0], {(NORM_W-QUO_W-REM_W+1){1'b0}}};
		norm_shift = !window[NORM_W-1]; // Quotient lies in [0.5, 2), one shift at most
		aligned = window << norm_shift;

		bias = header_i.fmt ? BIAS_DOUBLE : BIAS_SINGLE;
		biased_exp = header_i.exponent + bias - EXP_W'(norm_shift);

		sub_shift = '0;
		if (biased_exp <= 0) begin
			sub_shift = IDX_W'(SUBNORMAL_MAX_SHIFT);
			if (biased_exp > -SUBNORMAL_MAX_SHIFT) begin
				sub_shift = IDX_W'(1 - biased_exp);
			end
			biased_exp = '0;
		end
		shifted = aligned >> sub_shift;
	end

	always_comb begin
		result_d.sign = header_i.sign;
		result_d.exponent = biased_exp;
		if (header_i.fmt) begin
			result_d.mantissa = MANT_W'(shifted[NORM_W-1 -: DOUBLE_MANT_W]);
			result_d.grs = {shifted[DOUBLE_GUARD -: 2], |shifted[DOUBLE_GUARD-2:0]};
		end else begin
			result_d.mantissa = MANT_W'(shifted[NORM_W-1 -: SINGLE_MANT_W]);
			result_d.grs = {shifted[SINGLE_GUARD -: 2], |shifted[SINGLE_GUARD-2:0]};
		end
		result_d.fmt = header_i.fmt;
		result_d.rm = header_i.rm;
		result_d.flags = header_i.flags;
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			result_q <= '0;
		end else if (norm_en_i) begin
			result_q <= result_d;
		end
	end

	assign result_o = result_q;

endmodule

// ==== src/fp_fdiv.sv ====
`timescale 1ns/100ps

module fp_fdiv
	import fdiv_pkg::*;
(
	input  logic          clock,
	input  logic          reset,
	input  fdiv_request_t request_i,
	output fdiv_result_t  result_o,
	output logic          ready_o
);

	logic start;
	logic iterate_en;
	logic norm_en;
	logic [IDX_W-1:0] bit_index;
	fdiv_header_t header;
	logic [QUO_W-1:0] quotient;
	logic [REM_W-1:0] remainder;

	fdiv_control u_control (
		.clock        (clock),
		.reset        (reset),
		.op_i         (request_i.op),
		.header_fmt_i (header.fmt),
		.start_o      (start),
		.iterate_en_o (iterate_en),
		.bit_index_o  (bit_index),
		.norm_en_o    (norm_en),
		.ready_o      (ready_o)
	);

	fdiv_classify u_classify (
		.clock     (clock),
		.reset     (reset),
		.start_i   (start),
		.request_i (request_i),
		.header_o  (header)
	);

	fdiv_iterate u_iterate (
		.clock        (clock),
		.reset        (reset),
		.start_i      (start),
		.is_sqrt_i    (header.is_sqrt),
		.iterate_en_i (iterate_en),
		.bit_index_i  (bit_index),
		.dividend_i   (request_i.data1),
		.divisor_i    (request_i.data2),
		.quotient_o   (quotient),
		.remainder_o  (remainder)
	);

	fdiv_normalize u_normalize (
		.clock       (clock),
		.reset       (reset),
		.norm_en_i   (norm_en),
		.header_i    (header),
		.quotient_i  (quotient),
		.remainder_i (remainder),
		.result_o    (result_o)
	);

endmodule

// ==== tests/fdiv_model.svh ====
`ifndef FDIV_MODEL_SVH
`define FDIV_MODEL_SVH

function automatic fdiv_flags_t model_flags(input fdiv_request_t req);
	fdiv_flags_t flags;
	fp_class_t a;
	fp_class_t b;
	logic a_zero;
	logic a_inf;
	logic a_finite;
	logic b_zero;
	logic b_inf;
	logic b_finite;
	a = req.class1;
	b = (req.op == op_sqrt) ? '0 : req.class2; // A root has no divisor class
	a_zero = a[CLS_NEG_ZERO] | a[CLS_POS_ZERO];
	a_inf = a[CLS_NEG_INF] | a[CLS_POS_INF];
	a_finite = a[CLS_NEG_NORM] | a[CLS_NEG_SUB] | a[CLS_POS_SUB] | a[CLS_POS_NORM];
	b_zero = b[CLS_NEG_ZERO] | b[CLS_POS_ZERO];
	b_inf = b[CLS_NEG_INF] | b[CLS_POS_INF];
	b_finite = b_zero | b[CLS_NEG_NORM] | b[CLS_NEG_SUB] | b[CLS_POS_SUB] | b[CLS_POS_NORM];
	flags = '0;
	flags.snan = a[CLS_SNAN] | b[CLS_SNAN] | (a_zero & b_zero) | (a_inf & b_inf);
	flags.qnan = !flags.snan & (a[CLS_QNAN] | b[CLS_QNAN]);
	flags.inf = a_inf & b_finite;
	flags.dbz = !flags.inf & a_finite & b_zero;
	flags.zero = a_zero | b_inf;
	if (req.op == op_sqrt) begin
		flags.inf = flags.inf | a[CLS_POS_INF];
		flags.snan = flags.snan | a[CLS_NEG_INF] | a[CLS_NEG_NORM] | a[CLS_NEG_SUB];
	end
	return flags;
endfunction

function automatic fdiv_result_t model_result(input fdiv_request_t req);
	fdiv_result_t result;
	logic root;
	logic [63:0] rem;
	logic [63:0] quo;
	logic [63:0] sub;
	logic [63:0] twice;
	logic [NORM_W-1:0] window;
	int k;
	int last;
	int exponent;
	int shift;
	root = req.op == op_sqrt;
	rem = {11'd0, 1'b1, req.data1.fraction};
	if (root && !req.data1.exponent[0]) begin
		rem = rem << 1;
	end
	sub = {10'd0, 1'b1, req.data2.fraction, 1'b0};
	quo = '0;
	last = req.fmt ? 0 : 29;
	for (k = root ? 53 : 54; k >= last; k--) begin
		twice = rem << 1;
		if (root) begin
			sub = (quo << 1) + (64'd1 << k); // Twice the partial root plus the trial bit
		end
		if (twice >= sub) begin
			quo[k] = 1'b1;
			rem = twice - sub;
		end else begin
			rem = twice;
		end
	end
	if (root) begin
		exponent = (int'(req.data1.exponent) + int'(SQRT_EXP_OFFSET)) >>> 1;
	end else begin
		exponent = int'(req.data1.exponent) - int'(req.data2.exponent);
	end
	window = {quo[QUO_W-1:0], rem[REM_W-2:0], 54'd0};
	if (!window[NORM_W-1]) begin
		window = window << 1;
		exponent = exponent - 1;
	end
	exponent = exponent + (req.fmt ? int'(BIAS_DOUBLE) : int'(BIAS_SINGLE));
	if (exponent <= 0) begin
		shift = (1 - exponent > SUBNORMAL_MAX_SHIFT) ? SUBNORMAL_MAX_SHIFT : 1 - exponent;
		window = window >> shift;
		exponent = 0;
	end
	result = '0;
	result.sign = req.data1.sign ^ (req.data2.sign & !root);
	result.exponent = EXP_W'(exponent);
	if (req.fmt) begin
		result.mantissa = {1'b0, window[164:112]};
		result.grs = {window[111:110], |window[109:0]};
	end else begin
		result.mantissa = {30'd0, window[164:141]};
		result.grs = {window[140:139], |window[138:0]};
	end
	result.fmt = req.fmt;
	result.rm = req.rm;
	result.flags = model_flags(req);
	return result;
endfunction

function automatic int expected_latency(input fdiv_request_t req);
	int bits;
	if (req.op == op_sqrt) begin
		bits = req.fmt ? 54 : 25;
	end else begin
		bits = req.fmt ? 55 : 26;
	end
	return bits + 2; // Normalize cycle and ready cycle follow the last bit
endfunction

`endif

// ==== tests/fp_fdiv_tb.sv ====
`timescale 1ns/100ps

module fp_fdiv_tb
	import fdiv_pkg::*;
();

	localparam int READY_TIMEOUT = 100;

	logic clock;
	logic reset;
	fdiv_request_t request;
	fdiv_result_t result;
	logic ready;
	int seed;
	int result_errors;
	int flag_errors;
	int latency_errors;
	int other_errors;
	logic timed_out;

	`include "fdiv_model.svh"

	fp_fdiv UUT (
		.clock     (clock),
		.reset     (reset),
		.request_i (request),
		.result_o  (result),
		.ready_o   (ready)
	);

	always #10 clock = ~clock;

	function automatic int pick(input int span);
		return int'($unsigned($random(seed)) % span);
	endfunction

	function automatic operand_t random_operand(input logic [OPEXP_W-1:0] exponent);
		operand_t value;
		value.sign = 1'($random(seed));
		value.exponent = exponent;
		value.fraction = {20'($random(seed)), 32'($random(seed))};
		return value;
	endfunction

	function automatic fp_class_t normal_class(input logic sign);
		return sign ? fp_class_t'(1 << CLS_NEG_NORM) : fp_class_t'(1 << CLS_POS_NORM);
	endfunction

	function automatic fdiv_request_t normal_request(input fdiv_op_t op, input logic fmt);
		fdiv_request_t req;
		int low;
		int span;
		low = fmt ? 1024 : 1900; // Keeps most results in the normal range
		span = fmt ? 1024 : 300;
		req.op = op;
		req.data1 = random_operand(OPEXP_W'(low + pick(span)));
		req.data2 = random_operand(OPEXP_W'(low + pick(span)));
		req.class1 = normal_class(req.data1.sign);
		req.class2 = normal_class(req.data2.sign);
		req.fmt = fmt;
		req.rm = 3'(pick(5));
		return req;
	endfunction

	function automatic int compare_field(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
			return 1;
		end
		return 0;
	endfunction

	task automatic check_result(input fdiv_result_t expected, input fdiv_result_t actual);
		result_errors += compare_field("result_o.sign", 64'(expected.sign), 64'(actual.sign));
		result_errors += compare_field("result_o.exponent", 64'(expected.exponent),
			64'(actual.exponent));
		result_errors += compare_field("result_o.mantissa", 64'(expected.mantissa),
			64'(actual.mantissa));
		result_errors += compare_field("result_o.grs", 64'(expected.grs), 64'(actual.grs));
		result_errors += compare_field("result_o.fmt", 64'(expected.fmt), 64'(actual.fmt));
		result_errors += compare_field("result_o.rm", 64'(expected.rm), 64'(actual.rm));
	endtask

	task automatic check_flags(input fdiv_flags_t expected, input fdiv_flags_t actual);
		if (actual !== expected) begin
			flag_errors++;
			$display("error at %0t: result_o.flags expected %b got %b", $time, expected, actual);
		end
	endtask

	task automatic check_latency(input int expected, input int actual);
		if (actual != expected) begin
			latency_errors++;
			$display("error at %0t: ready_o latency expected %0d got %0d", $time, expected, actual);
		end
	endtask

	task automatic run_job(input fdiv_request_t req, input logic disturb);
		fdiv_result_t expected;
		fdiv_result_t held;
		int cycles;
		expected = model_result(req);
		request = req;
		cycles = 0;
		do begin
			@(posedge clock);
			#2;
			cycles++;
			request.op = op_none;
			if (disturb && !ready) begin
				request = normal_request(pick(2) ? op_sqrt : op_div, 1'(pick(2))); // Busy, must be dropped
			end
		end while (!ready && cycles < READY_TIMEOUT);
		request.op = op_none;
		if (!ready) begin
			other_errors++;
			timed_out = 1'b1;
			$display("timeout: ready_o did not rise within %0d cycles of the start", READY_TIMEOUT);
			return;
		end
		check_latency(expected_latency(req), cycles);
		check_result(expected, result);
		check_flags(expected.flags, result.flags);
		held = result;
		repeat (3) begin
			@(posedge clock);
			#2;
			if (ready !== 1'b0) begin
				other_errors++;
				$display("ready_o pulsed again at %0t with no new request", $time);
			end
			if (result !== held) begin
				other_errors++;
				$display("result_o changed at %0t after the job had ended", $time);
			end
		end
	endtask

	initial begin
		fdiv_request_t req;
		int n;
		int i;
		int j;
		seed = 69929;
		clock = 1'b0;
		reset = 1'b0;
		request = normal_request(op_div, 1'b1); // A job requested during reset must not start
		result_errors = 0;
		flag_errors = 0;
		latency_errors = 0;
		other_errors = 0;
		timed_out = 1'b0;
		repeat (16) begin
			@(posedge clock);
			#2;
			if (ready !== 1'b0) begin
				other_errors++;
				$display("ready_o went high at %0t while reset was asserted", $time);
			end
		end
		if (result !== '0) begin
			other_errors++;
			$display("result_o is not zero after reset");
		end
		reset = 1'b1;
		request.op = op_none;
		@(posedge clock);
		#2;
		for (n = 0; n < 40 && !timed_out; n++) begin
			run_job(normal_request(op_div, 1'b1), 1'b0);
		end
		for (n = 0; n < 40 && !timed_out; n++) begin
			run_job(normal_request((n % 2 == 1) ? op_sqrt : op_div, 1'b0), 1'b0);
		end
		for (i = 0; i < CLASS_W && !timed_out; i++) begin
			for (j = 0; j < CLASS_W && !timed_out; j++) begin
				req = normal_request(op_div, 1'((i + j) % 2)); // Every class pair once
				req.class1 = fp_class_t'(1 << i);
				req.class2 = fp_class_t'(1 << j);
				run_job(req, 1'b0);
			end
			req = normal_request(op_sqrt, 1'(i % 2));
			req.class1 = fp_class_t'(1 << i);
			if (!timed_out) begin
				run_job(req, 1'b0);
			end
		end
		for (n = 0; n < 40 && !timed_out; n++) begin
			req = normal_request(op_div, 1'(n % 2));
			req.data1.exponent = OPEXP_W'(64 + pick(64));
			req.data2.exponent = req.data1.exponent
				+ OPEXP_W'(req.fmt ? 1024 + pick(100) : 128 + pick(100)); // Reaches the shift cap
			run_job(req, 1'b0);
		end
		for (n = 0; n < 10 && !timed_out; n++) begin
			run_job(normal_request(op_div, 1'(n % 2)), 1'b1);
		end
		$display("errors: result %0d, flags %0d, latency %0d, other %0d",
			result_errors, flag_errors, latency_errors, other_errors);
		if (result_errors + flag_errors + latency_errors + other_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== fp_fdiv.f ====
+incdir+tests
src/fdiv_pkg.sv
src/fdiv_control.sv
src/fdiv_classify.sv
src/fdiv_iterate.sv
src/fdiv_normalize.sv
src/fp_fdiv.sv
tests/fp_fdiv_tb.sv

// ==== Makefile ====
VERILATOR = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS = --binary --timing --assert
TOP = fp_fdiv_tb
RTL_TOP = fp_fdiv
FILELIST = fp_fdiv.f
BUILD_DIR = obj_dir
LOG = sim.log
FAIL_MSG = Test FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
		if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
